// ==== fetch_unit.f ====
source/fetch_pkg.sv
source/cache_mem_if.sv
source/icache_mem.sv
source/icache_ctrl.sv
source/if_stage.sv
source/fetch_unit.sv
verif/mem_model.sv
verif/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f fetch_unit.f \
	--top-module tb_fetch_unit \
	-o sim_fetch_unit

./obj_dir/sim_fetch_unit > sim.log
cat sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation FAILED, see sim.log"
	exit 1
fi

// ==== verif/tb_fetch_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the fetch unit with the tagged memory model
// random stall levels and redirects into a 512 byte window
// inputs change on the falling edge, checks sample at the rising edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_fetch_unit import fetch_pkg::*; ();

	localparam int reset_cycles = 16;
	localparam int warmup_cycles = 40;
	localparam int run_cycles = 3000;
	// generous margin over the run length
	localparam int timeout_cycles = run_cycles + 1000;

	logic            clock = 1'b0;
	logic            reset;
	logic            stall;
	logic            redirect_valid;
	logic [xlen-1:0] redirect_pc;

	mem_tag_t             mem2proc_response;
	mem_tag_t             mem2proc_tag;
	logic [line_bits-1:0] mem2proc_data;
	mem_cmd_t             proc2mem_command;
	logic [xlen-1:0]      proc2mem_addr;

	logic            fetch_valid;
	logic [xlen-1:0] fetch_pc;
	logic [xlen-1:0] fetch_inst;

	// reference state
	logic [xlen-1:0] expect_pc;
	logic [xlen-1:0] expect_inst;
	logic            fetched_any;
	logic            redirected_any;
	int              reset_edges = 0;

	int cycle_count = 0;
	int fetch_count = 0;
	int redirect_count = 0;
	int fetch_errors = 0;

	// instruction stored at a byte address
	function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] addr);
		return (addr * 32'd3) ^ 32'h5a5a0000;
	endfunction

	always #20 clock = ~clock;

	fetch_unit fetch_unit_inst (
		.clock             (clock),
		.reset             (reset),
		.stall             (stall),
		.redirect_valid    (redirect_valid),
		.redirect_pc       (redirect_pc),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.fetch_valid       (fetch_valid),
		.fetch_pc          (fetch_pc),
		.fetch_inst        (fetch_inst)
	);

	mem_model mem_model_inst (
		.clock             (clock),
		.reset             (reset),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int unsigned stall_left;
		void'($urandom(26520));
		reset = 1'b1;
		stall = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		stall_left = 0;
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		// quiet start so the first fetch comes from pc 0
		repeat (warmup_cycles) @(negedge clock);
		repeat (run_cycles - reset_cycles - warmup_cycles) begin
			@(negedge clock);
			// stall held at one level for 1 to 8 cycles
			if (stall_left == 0) begin
				stall = ($urandom % 4 == 0);
				stall_left = 1 + $urandom % 8;
			end
			stall_left--;
			redirect_valid = ($urandom % 32 == 0);
			redirect_pc = ($urandom % 128) * 4;
		end
		@(negedge clock);
		if (fetch_count == 0) begin
			fetch_errors++;
			$display("no instruction was fetched during the run");
		end
		$display("fetches %0d, redirects %0d, fetch errors %0d, bus errors %0d",
			fetch_count, redirect_count, fetch_errors, mem_model_inst.bus_errors);
		if (fetch_errors == 0 && mem_model_inst.bus_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// run limit
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("run did not finish within %0d cycles", timeout_cycles);
			$display("Checks failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference pc and checks
	////////////////////////////////////////////////////////////////////////////

	assign expect_inst = word_at(fetch_pc);

	// expected pc follows a redirect or steps by 4 after a fetch
	always @(posedge clock) begin
		if (reset) begin
			reset_edges <= reset_edges + 1;
			expect_pc <= '0;
			fetched_any <= 1'b0;
			redirected_any <= 1'b0;
		end else if (redirect_valid) begin
			expect_pc <= redirect_pc;
			redirected_any <= 1'b1;
			redirect_count <= redirect_count + 1;
		end else if (fetch_valid) begin
			expect_pc <= expect_pc + 32'd4;
			fetched_any <= 1'b1;
			fetch_count <= fetch_count + 1;
		end
	end

	// quiet outputs while reset holds
	assert property (@(posedge clock)
		reset && reset_edges > 0 |-> !fetch_valid)
	else begin
		fetch_errors++;
		$display("Error at %0t: fetch_valid expected 0 got %b", $time, $sampled(fetch_valid));
	end

	assert property (@(posedge clock)
		reset && reset_edges > 0 |-> proc2mem_command == bus_none)
	else begin
		fetch_errors++;
		$display("Error at %0t: proc2mem_command expected %0d got %0d", $time,
			bus_none, $sampled(proc2mem_command));
	end

	assert property (@(posedge clock) disable iff (reset)
		fetch_valid && !fetched_any && !redirected_any |-> fetch_pc == '0)
	else begin
		fetch_errors++;
		$display("Error at %0t: fetch_pc expected 0 got %h", $time, $sampled(fetch_pc));
	end

	assert property (@(posedge clock) disable iff (reset)
		fetch_valid |-> fetch_inst == expect_inst)
	else begin
		fetch_errors++;
		$display("Error at %0t: fetch_inst expected %h got %h", $time,
			$sampled(expect_inst), $sampled(fetch_inst));
	end

	assert property (@(posedge clock) disable iff (reset)
		fetch_valid |-> fetch_pc == expect_pc)
	else begin
		fetch_errors++;
		$display("Error at %0t: fetch_pc expected %h got %h", $time,
			$sampled(expect_pc), $sampled(fetch_pc));
	end

	// no fetch under stall or redirect
	assert property (@(posedge clock) disable iff (reset)
		stall || redirect_valid |-> !fetch_valid)
	else begin
		fetch_errors++;
		$display("Error at %0t: fetch_valid expected 0 got %b", $time, $sampled(fetch_valid));
	end

endmodule

// ==== verif/mem_model.sv ====
////////////////////////////////////////////////////////////////////////////
// tagged memory model for the fetch unit bus, loads only
// answers a load in the same cycle, refuses about one in four
// data returns 2 to 9 cycles after the accept, tags rotate over 1..15
// word at byte address a is a*3 xor 5a5a0000
// also checks bus alignment, one outstanding load and line refetch
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_model import fetch_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  mem_cmd_t             proc2mem_command,
	input  logic [xlen-1:0]      proc2mem_addr,
	output mem_tag_t             mem2proc_response,
	output mem_tag_t             mem2proc_tag,
	output logic [line_bits-1:0] mem2proc_data
);

	int bus_errors = 0;

	// the one load in flight
	logic            pending;
	mem_tag_t        pend_tag;
	logic [xlen-1:0] pend_addr;
	int unsigned     delay;
	mem_tag_t        next_tag;

	// lines seen filled, per index
	logic [num_lines-1:0] filled;
	logic [xlen-1:0]      filled_addr [num_lines];

	logic [idx_bits-1:0]  req_idx;
	logic                 refetch;

	// two instructions of the line at an aligned address
	function automatic logic [line_bits-1:0] line_at(input logic [xlen-1:0] addr);
		logic [xlen-1:0] low;
		logic [xlen-1:0] high;
		low = (addr * 32'd3) ^ 32'h5a5a0000;
		high = ((addr + 32'd4) * 32'd3) ^ 32'h5a5a0000;
		return {high, low};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// bus responses, driven on the falling edge
	////////////////////////////////////////////////////////////////////////////

	initial begin
		mem2proc_response = tag_none;
		mem2proc_tag = tag_none;
		mem2proc_data = '0;
		forever begin
			@(negedge clock);
			// accept or refuse whatever load is on the bus
			if (proc2mem_command == bus_load && $urandom % 4 != 0) begin
				mem2proc_response = next_tag;
			end else begin
				mem2proc_response = tag_none;
			end
			// data only in the return cycle, noise otherwise
			if (pending && delay == 0) begin
				mem2proc_tag = pend_tag;
				mem2proc_data = line_at(pend_addr);
			end else begin
				mem2proc_tag = tag_none;
				mem2proc_data = {$urandom, $urandom};
			end
		end
	end

	// transaction state, follows the accept and the return
	always @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
			next_tag <= 4'd1;
			filled <= '0;
			delay <= 0;
		end else begin
			if (pending && delay == 0) begin
				pending <= 1'b0;
				filled[pend_addr[off_bits +: idx_bits]] <= 1'b1;
				filled_addr[pend_addr[off_bits +: idx_bits]] <= pend_addr;
			end else if (pending) begin
				delay <= delay - 1;
			end
			if (proc2mem_command == bus_load && mem2proc_response != tag_none) begin
				pending <= 1'b1;
				pend_tag <= mem2proc_response;
				pend_addr <= proc2mem_addr;
				delay <= 1 + $urandom % 8;
				// zero stays reserved
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bus checks
	////////////////////////////////////////////////////////////////////////////

	// request for a line that is already in the cache
	assign req_idx = proc2mem_addr[off_bits +: idx_bits];
	assign refetch = (proc2mem_command == bus_load) && filled[req_idx]
		&& (filled_addr[req_idx] == proc2mem_addr);

	assert property (@(posedge clock) disable iff (reset)
		proc2mem_command == bus_load |-> proc2mem_addr[off_bits-1:0] == '0)
	else begin
		bus_errors++;
		$display("Error at %0t: proc2mem_addr[2:0] expected 0 got %0d", $time,
			$sampled(proc2mem_addr[off_bits-1:0]));
	end

	assert property (@(posedge clock) disable iff (reset)
		pending |-> proc2mem_command != bus_load)
	else begin
		bus_errors++;
		$display("Error at %0t: proc2mem_command expected %0d got %0d", $time,
			bus_none, $sampled(proc2mem_command));
	end

	assert property (@(posedge clock) disable iff (reset) !refetch)
	else begin
		bus_errors++;
		$display("line %h was requested again after it was filled", $sampled(proc2mem_addr));
	end

endmodule

// ==== source/fetch_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction fetch front end, top level
// fetch stage, icache controller and direct mapped cache storage
// memory bus uses plain strobes with tagged responses, loads only
// stall holds the pc, redirect loads a new pc at the next edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_unit import fetch_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,

	// control from later stages
	input  logic                 stall,
	input  logic                 redirect_valid,
	input  logic [xlen-1:0]      redirect_pc,

	// memory bus
	input  mem_tag_t             mem2proc_response,
	input  mem_tag_t             mem2proc_tag,
	input  logic [line_bits-1:0] mem2proc_data,
	output mem_cmd_t             proc2mem_command,
	output logic [xlen-1:0]      proc2mem_addr,

	// fetched instruction
	output logic                 fetch_valid,
	output logic [xlen-1:0]      fetch_pc,
	output logic [xlen-1:0]      fetch_inst
);

	// fetch stage to controller
	fetch_addr_t          fetch_addr;
	logic [line_bits-1:0] line_data;
	logic                 line_valid;

	// controller to storage
	cache_mem_if cmem ();

	// pc and instruction select
	if_stage if_stage_inst (
		.clock          (clock),
		.reset          (reset),
		.stall          (stall),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.line_data      (line_data),
		.line_valid     (line_valid),
		.fetch_addr     (fetch_addr),
		.fetch_valid    (fetch_valid),
		.fetch_pc       (fetch_pc),
		.fetch_inst     (fetch_inst)
	);

	// hit check and miss handling
	icache_ctrl icache_ctrl_inst (
		.clock             (clock),
		.reset             (reset),
		.fetch_addr        (fetch_addr),
		.line_data         (line_data),
		.line_valid        (line_valid),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.cmem              (cmem.ctrl)
	);

	// line storage
	icache_mem icache_mem_inst (
		.clock (clock),
		.reset (reset),
		.cmem  (cmem.mem)
	);

endmodule

// ==== source/if_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch stage, holds the program counter
// redirect wins over stall and over a fetch in the same cycle
// the pc moves by 4 only after a cycle with fetch_valid high
// fetch outputs are combinational from the pc and the cache line
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module if_stage import fetch_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,

	// control
	input  logic                 stall,
	input  logic                 redirect_valid,
	input  logic [xlen-1:0]      redirect_pc,

	// cache side
	input  logic [line_bits-1:0] line_data,
	input  logic                 line_valid,
	output fetch_addr_t          fetch_addr,

	// fetched instruction
	output logic                 fetch_valid,
	output logic [xlen-1:0]      fetch_pc,
	output logic [xlen-1:0]      fetch_inst
);

	// program counter
	logic [xlen-1:0] pc;
	logic [xlen-1:0] next_pc;

	// cache looks up the current pc
	assign fetch_addr.word = pc;

	// valid only on a hit with no stall and no redirect
	assign fetch_valid = line_valid && !stall && !redirect_valid;

	assign fetch_pc = pc;

	// offset bit 2 picks the high word of the line
	always_comb begin
		if (fetch_addr.fields.offset[2]) begin
			fetch_inst = line_data[line_bits-1:xlen];
		end else begin
			fetch_inst = line_data[xlen-1:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pc update
	////////////////////////////////////////////////////////////////////////////

	// redirect, then advance, else hold
	always_comb begin
		next_pc = pc;
		if (redirect_valid) begin
			next_pc = redirect_pc;
		end else if (fetch_valid) begin
			next_pc = pc + 32'd4;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

// ==== source/icache_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction cache controller, one outstanding miss at a time
// a miss with nothing pending drives bus_load with the line address
// a zero response means refused, the request repeats next cycle
// the fill happens when the returning tag matches the saved one
// no request goes out in the first cycle after reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module icache_ctrl import fetch_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,

	// fetch side
	input  fetch_addr_t          fetch_addr,
	output logic [line_bits-1:0] line_data,
	output logic                 line_valid,

	// memory bus
	input  mem_tag_t             mem2proc_response,
	input  mem_tag_t             mem2proc_tag,
	input  logic [line_bits-1:0] mem2proc_data,
	output mem_cmd_t             proc2mem_command,
	output logic [xlen-1:0]      proc2mem_addr,

	// cache storage
	cache_mem_if.ctrl            cmem
);

	// request allowed once reset has passed
	logic                armed;

	// a transaction is in flight
	logic                busy;

	// accepted tag and the line it belongs to
	mem_tag_t            pend_tag;
	logic [idx_bits-1:0] miss_idx;
	logic [tag_bits-1:0] miss_tag;

	// bus events this cycle
	logic                accept;
	logic                fill;

	////////////////////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////////////////////

	// index and tag from the field view of the address
	assign cmem.rd_idx = fetch_addr.fields.index;
	assign cmem.rd_tag = fetch_addr.fields.tag;

	assign line_data = cmem.rd_data;
	assign line_valid = cmem.rd_hit;

	////////////////////////////////////////////////////////////////////////////
	// miss request
	////////////////////////////////////////////////////////////////////////////

	// load on a miss, only with nothing outstanding
	always_comb begin
		proc2mem_command = bus_none;
		if (armed && !busy && !cmem.rd_hit) begin
			proc2mem_command = bus_load;
		end
	end

	// line aligned address
	assign proc2mem_addr = {fetch_addr.word[xlen-1:off_bits], {off_bits{1'b0}}};

	// memory took the request when the response is nonzero
	assign accept = (proc2mem_command == bus_load) && (mem2proc_response != tag_none);

	// data for our transaction is on the bus
	assign fill = busy && (mem2proc_tag == pend_tag);

	// outstanding state
	always_ff @(posedge clock) begin
		if (reset) begin
			armed <= 1'b0;
			busy <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (accept) begin
				busy <= 1'b1;
			end else if (fill) begin
				busy <= 1'b0;
			end
		end
	end

	// saved tag and miss location, only read while busy
	always_ff @(posedge clock) begin
		if (accept) begin
			pend_tag <= mem2proc_response;
			miss_idx <= fetch_addr.fields.index;
			miss_tag <= fetch_addr.fields.tag;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// line fill
	////////////////////////////////////////////////////////////////////////////

	// one cycle write straight from the bus
	assign cmem.wr_en = fill;
	assign cmem.wr_idx = miss_idx;
	assign cmem.wr_tag = miss_tag;
	assign cmem.wr_data = mem2proc_data;

endmodule

// ==== source/icache_mem.sv ====
////////////////////////////////////////////////////////////////////////////
// direct mapped instruction cache storage, 32 lines of 64 bits
// read and hit compare are combinational
// a fill writes data, tag and valid bit at the clock edge
// reset clears only the valid bits, data and tags come up unknown
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module icache_mem import fetch_pkg::*; (
	input logic       clock,
	input logic       reset,
	cache_mem_if.mem  cmem
);

	// line data and tags
	logic [line_bits-1:0] data [num_lines];
	logic [tag_bits-1:0]  tags [num_lines];

	// one valid bit per line
	logic [num_lines-1:0] valid;

	// stored entry at the lookup index
	logic [tag_bits-1:0]  stored_tag;
	logic                 stored_valid;

	////////////////////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		stored_tag = tags[cmem.rd_idx];
		stored_valid = valid[cmem.rd_idx];
	end

	// hit needs a valid line and a matching tag
	assign cmem.rd_hit = stored_valid && (stored_tag == cmem.rd_tag);

	// data goes out even on a miss, the hit qualifies it
	assign cmem.rd_data = data[cmem.rd_idx];

	////////////////////////////////////////////////////////////////////////////
	// fill
	////////////////////////////////////////////////////////////////////////////

	// valid bits, cleared on reset
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (cmem.wr_en) begin
			valid[cmem.wr_idx] <= 1'b1;
		end
	end

	// payload, no reset
	always_ff @(posedge clock) begin
		if (cmem.wr_en) begin
			data[cmem.wr_idx] <= cmem.wr_data;
			tags[cmem.wr_idx] <= cmem.wr_tag;
		end
	end

endmodule

// ==== source/cache_mem_if.sv ====
////////////////////////////////////////////////////////////////////////////
// link between the icache controller and the cache storage
// read side has no handshake, hit is valid in the same cycle
// wr_en is a single-cycle pulse, the write lands at the next edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface cache_mem_if import fetch_pkg::*; ();

	// lookup, driven by the controller
	logic [idx_bits-1:0]  rd_idx;
	logic [tag_bits-1:0]  rd_tag;

	// lookup result, driven by the storage
	logic [line_bits-1:0] rd_data;
	logic                 rd_hit;

	// line fill from the controller
	logic                 wr_en;
	logic [idx_bits-1:0]  wr_idx;
	logic [tag_bits-1:0]  wr_tag;
	logic [line_bits-1:0] wr_data;

	// controller side
	modport ctrl (
		output rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data,
		input  rd_data, rd_hit
	);

	// storage side
	modport mem (
		input  rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data,
		output rd_data, rd_hit
	);

endinterface

// ==== source/fetch_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared definitions for the instruction fetch front end
// cache geometry is fixed here: 32 lines of 8 bytes, direct mapped
// changing line_bytes or num_lines also reshapes the address union
// only bus_none and bus_load are ever driven by the fetch unit
// a memory tag of zero means refused or no data
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

	// word width for addresses and instructions
	localparam int xlen = 32;

	// cache geometry
	localparam int line_bytes = 8;
	localparam int num_lines = 32;
	localparam int line_bits = line_bytes * 8;
	localparam int off_bits = $clog2(line_bytes);
	localparam int idx_bits = $clog2(num_lines);
	localparam int tag_bits = 8;
	// address bits above the tag, ignored by the cache
	localparam int high_bits = xlen - tag_bits - idx_bits - off_bits;

	// memory bus command, encoding as on the memory side
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} mem_cmd_t;

	// transaction tag, zero is reserved
	typedef logic [3:0] mem_tag_t;
	localparam mem_tag_t tag_none = 4'h0;

	// fetch address, seen as a pc word or as cache fields
	typedef union packed {
		logic [xlen-1:0] word;
		struct packed {
			logic [high_bits-1:0] high;
			logic [tag_bits-1:0]  tag;
			logic [idx_bits-1:0]  index;
			// bit 2 picks the instruction within the line
			logic [off_bits-1:0]  offset;
		} fields;
	} fetch_addr_t;

endpackage
